// File: hdl/motorSettings.svh
`ifndef MOTOR_SETTINGS_SVH
`define MOTOR_SETTINGS_SVH

// datapath widths
`define MOTOR_PERIOD_W      12
`define MOTOR_CREDIT_W      16
`define MOTOR_STEP_LEN_W    25
`define MOTOR_STEP_W        4
`define MOTOR_ADDR_W        8

// commutation sequence, steps 6 and 11 compare against a neighbor phase
`define MOTOR_STEP_COUNT    12
`define MOTOR_STEP_B        6
`define MOTOR_STEP_C        11

// register map, word aligned
`define MOTOR_REG_CTRL      8'h00
`define MOTOR_REG_PERIOD    8'h04
`define MOTOR_REG_MINW      8'h08
`define MOTOR_REG_STEPLEN   8'h0C
`define MOTOR_REG_CREDIT_A  8'h10
`define MOTOR_REG_CREDIT_B  8'h14
`define MOTOR_REG_CREDIT_C  8'h18
`define MOTOR_REG_STEP      8'h1C
`define MOTOR_REG_WANT_A    8'h20
`define MOTOR_REG_WANT_B    8'h24
`define MOTOR_REG_WANT_C    8'h28
`define MOTOR_REG_REAL_A    8'h2C
`define MOTOR_REG_REAL_B    8'h30
`define MOTOR_REG_REAL_C    8'h34

`endif

// File: hdl/motorPkg.sv
`include "motorSettings.svh"

package motorPkg;

    // APB request as seen by the slave
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`MOTOR_ADDR_W-1:0]   paddr;
        logic [31:0]                pwdata;
    } apbReq;

    // APB response, pready is tied high in this design
    typedef struct packed {
        logic [31:0]                prdata;
        logic                       pready;
        logic                       pslverr;
    } apbRsp;

    // configuration shared by the timer and all phases
    typedef struct packed {
        logic                           enable;
        logic [`MOTOR_PERIOD_W-1:0]     periodLen;
        logic [`MOTOR_PERIOD_W-1:0]     minWidth;
        logic [`MOTOR_STEP_LEN_W-1:0]   stepLen;
        logic [`MOTOR_CREDIT_W-1:0]     creditA;
        logic [`MOTOR_CREDIT_W-1:0]     creditB;
        logic [`MOTOR_CREDIT_W-1:0]     creditC;
    } motorCfg;

    // totals of the last finished step
    typedef struct packed {
        logic [`MOTOR_CREDIT_W-1:0]     wantSum;
        logic [`MOTOR_CREDIT_W-1:0]     realCount;
    } phaseStatus;

endpackage

// File: hdl/motorRegs.sv
`include "motorSettings.svh"

module motorRegs (
    input  logic                        clk,
    input  logic                        rstN,
    input  motorPkg::apbReq             req,
    output motorPkg::apbRsp             rsp,
    input  logic [`MOTOR_STEP_W-1:0]    step,
    input  motorPkg::phaseStatus        statusA,
    input  motorPkg::phaseStatus        statusB,
    input  motorPkg::phaseStatus        statusC,
    output motorPkg::motorCfg           cfg
);
    import motorPkg::*;

    motorCfg        cfgQ;
    logic           access;
    logic           mapped;
    logic           readOnly;
    logic           wrEn;
    logic [31:0]    rdData;

    // second phase of a transfer, pready is always high
    assign access = req.psel & req.penable;

    // address decode and read mux
    always_comb begin
        mapped   = 1'b1;
        readOnly = 1'b0;
        rdData   = '0;
        case (req.paddr)
            `MOTOR_REG_CTRL:     rdData = 32'(cfgQ.enable);
            `MOTOR_REG_PERIOD:   rdData = 32'(cfgQ.periodLen);
            `MOTOR_REG_MINW:     rdData = 32'(cfgQ.minWidth);
            `MOTOR_REG_STEPLEN:  rdData = 32'(cfgQ.stepLen);
            `MOTOR_REG_CREDIT_A: rdData = 32'(cfgQ.creditA);
            `MOTOR_REG_CREDIT_B: rdData = 32'(cfgQ.creditB);
            `MOTOR_REG_CREDIT_C: rdData = 32'(cfgQ.creditC);
            `MOTOR_REG_STEP: begin
                rdData   = 32'(step);
                readOnly = 1'b1;
            end
            `MOTOR_REG_WANT_A: begin
                rdData   = 32'(statusA.wantSum);
                readOnly = 1'b1;
            end
            `MOTOR_REG_WANT_B: begin
                rdData   = 32'(statusB.wantSum);
                readOnly = 1'b1;
            end
            `MOTOR_REG_WANT_C: begin
                rdData   = 32'(statusC.wantSum);
                readOnly = 1'b1;
            end
            `MOTOR_REG_REAL_A: begin
                rdData   = 32'(statusA.realCount);
                readOnly = 1'b1;
            end
            `MOTOR_REG_REAL_B: begin
                rdData   = 32'(statusB.realCount);
                readOnly = 1'b1;
            end
            `MOTOR_REG_REAL_C: begin
                rdData   = 32'(statusC.realCount);
                readOnly = 1'b1;
            end
            default: mapped = 1'b0;
        endcase
    end

    // only mapped writable addresses update the config
    assign wrEn = access & req.pwrite & mapped & ~readOnly;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfgQ <= '0;
        end else if (wrEn) begin
            case (req.paddr)
                `MOTOR_REG_CTRL:     cfgQ.enable    <= req.pwdata[0];
                `MOTOR_REG_PERIOD:   cfgQ.periodLen <= req.pwdata[`MOTOR_PERIOD_W-1:0];
                `MOTOR_REG_MINW:     cfgQ.minWidth  <= req.pwdata[`MOTOR_PERIOD_W-1:0];
                `MOTOR_REG_STEPLEN:  cfgQ.stepLen   <= req.pwdata[`MOTOR_STEP_LEN_W-1:0];
                `MOTOR_REG_CREDIT_A: cfgQ.creditA   <= req.pwdata[`MOTOR_CREDIT_W-1:0];
                `MOTOR_REG_CREDIT_B: cfgQ.creditB   <= req.pwdata[`MOTOR_CREDIT_W-1:0];
                `MOTOR_REG_CREDIT_C: cfgQ.creditC   <= req.pwdata[`MOTOR_CREDIT_W-1:0];
                default:             cfgQ           <= cfgQ;
            endcase
        end
    end

    assign cfg         = cfgQ;
    assign rsp.prdata  = rdData;
    assign rsp.pready  = 1'b1;
    // unmapped access or a write to a status register
    assign rsp.pslverr = access & (~mapped | (req.pwrite & readOnly));

endmodule

// File: hdl/commutationTimer.sv
`include "motorSettings.svh"

module commutationTimer (
    input  logic                        clk,
    input  logic                        rstN,
    input  motorPkg::motorCfg           cfg,
    output logic                        stepLast,
    output logic                        stepFirst,
    output logic [`MOTOR_STEP_W-1:0]    step
);

    logic [`MOTOR_STEP_LEN_W-1:0]   stepCnt;
    logic [`MOTOR_STEP_LEN_W-1:0]   stepEnd;
    logic                           stepWrap;

    // last count value of a step
    assign stepEnd = cfg.stepLen - 1'b1;

    assign stepLast = cfg.enable & (stepCnt == stepEnd);

    // step 11 rolls back to step 0
    assign stepWrap = (step == (`MOTOR_STEP_COUNT - 1));

    // cycle counter within the current step
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stepCnt <= '0;
        end else if (!cfg.enable) begin
            stepCnt <= '0;
        end else if (stepLast) begin
            stepCnt <= '0;
        end else begin
            stepCnt <= stepCnt + 1'b1;
        end
    end

    // first cycle of the following step
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stepFirst <= 1'b0;
        end else if (!cfg.enable) begin
            stepFirst <= 1'b0;
        end else begin
            stepFirst <= stepLast;
        end
    end

    // step sequencer, held at 0 while disabled
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            step <= '0;
        end else if (!cfg.enable) begin
            step <= '0;
        end else if (stepLast) begin
            if (stepWrap) begin
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

endmodule

// File: hdl/pwmGenerator.sv
`include "motorSettings.svh"

module pwmGenerator (
    input  logic                            clk,
    input  logic                            rstN,
    input  motorPkg::motorCfg               cfg,
    input  logic [`MOTOR_CREDIT_W-1:0]      credit,
    input  logic [`MOTOR_STEP_W-1:0]        step,
    input  logic                            stepLast,
    input  logic                            stepFirst,
    input  logic [`MOTOR_CREDIT_W-1:0]      limitB,
    input  logic [`MOTOR_CREDIT_W-1:0]      limitC,
    output logic [`MOTOR_CREDIT_W-1:0]      creditSum,
    output motorPkg::phaseStatus            status,
    output logic                            pwm
);
    import motorPkg::*;

    logic [`MOTOR_PERIOD_W-1:0]     periodCnt;
    logic                           reload;
    logic                           reloadQ;
    logic                           periodStart;

    logic [`MOTOR_CREDIT_W-1:0]     remainder;
    logic [`MOTOR_CREDIT_W-1:0]     sum;
    logic                           holdBack;
    logic [`MOTOR_CREDIT_W-1:0]     pulseCnt;

    logic [`MOTOR_CREDIT_W-1:0]     wantAcc;
    logic [`MOTOR_CREDIT_W-1:0]     realAcc;
    phaseStatus                     statusQ;

    // period ends on count 1, at a step boundary, or stays parked with no credit
    assign reload = (periodCnt == 1) | stepLast | (credit == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            periodCnt <= '0;
            reloadQ   <= 1'b0;
        end else begin
            reloadQ <= reload;
            if (reload) begin
                periodCnt <= cfg.periodLen;
            end else begin
                periodCnt <= periodCnt - 1'b1;
            end
        end
    end

    assign periodStart = reloadQ & ~reload;

    // credit plus whatever was carried from earlier periods
    assign sum       = remainder + credit;
    assign creditSum = sum;

    // too short, or the neighbor phase is below us in the limited steps
    always_comb begin
        holdBack = (sum < cfg.minWidth);
        if ((step == `MOTOR_STEP_B) && (limitB < sum)) begin
            holdBack = 1'b1;
        end
        if ((step == `MOTOR_STEP_C) && (limitC < sum)) begin
            holdBack = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            remainder <= '0;
            pulseCnt  <= '0;
        end else if (periodStart) begin
            remainder <= holdBack ? sum : '0;
            pulseCnt  <= holdBack ? '0 : sum;
        end else if (pulseCnt != '0) begin
            // a long pulse may run past the next reload
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    assign pwm = (pulseCnt != '0);

    // per step totals; a new step starts counting with its own first cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wantAcc <= '0;
            realAcc <= '0;
            statusQ <= '0;
        end else if (stepFirst) begin
            statusQ.wantSum   <= wantAcc;
            statusQ.realCount <= realAcc;
            wantAcc           <= periodStart ? credit : '0;
            realAcc           <= `MOTOR_CREDIT_W'(pwm);
        end else begin
            if (periodStart) begin
                wantAcc <= wantAcc + credit;
            end
            if (pwm) begin
                realAcc <= realAcc + 1'b1;
            end
        end
    end

    assign status = statusQ;

endmodule

// File: hdl/motorPwmTop.sv
`include "motorSettings.svh"

module motorPwmTop (
    input  logic                clk,
    input  logic                rstN,
    input  motorPkg::apbReq     apb,
    output motorPkg::apbRsp     apbResp,
    output logic                pwmA,
    output logic                pwmB,
    output logic                pwmC
);
    import motorPkg::*;

    motorCfg                        cfg;
    phaseStatus                     statusA;
    phaseStatus                     statusB;
    phaseStatus                     statusC;
    logic                           stepLast;
    logic                           stepFirst;
    logic [`MOTOR_STEP_W-1:0]       step;
    logic [`MOTOR_CREDIT_W-1:0]     sumA;
    logic [`MOTOR_CREDIT_W-1:0]     sumB;
    logic [`MOTOR_CREDIT_W-1:0]     sumC;

    motorRegs u_motorRegs (
        .clk     (clk),
        .rstN    (rstN),
        .req     (apb),
        .rsp     (apbResp),
        .step    (step),
        .statusA (statusA),
        .statusB (statusB),
        .statusC (statusC),
        .cfg     (cfg)
    );

    commutationTimer u_commutationTimer (
        .clk       (clk),
        .rstN      (rstN),
        .cfg       (cfg),
        .stepLast  (stepLast),
        .stepFirst (stepFirst),
        .step      (step)
    );

    // limit inputs rotate so each phase sees its two neighbors
    pwmGenerator phaseA (
        .clk (clk), .rstN (rstN), .cfg (cfg), .credit (cfg.creditA), .step (step),
        .stepLast (stepLast), .stepFirst (stepFirst), .limitB (sumB), .limitC (sumC),
        .creditSum (sumA), .status (statusA), .pwm (pwmA)
    );

    pwmGenerator phaseB (
        .clk (clk), .rstN (rstN), .cfg (cfg), .credit (cfg.creditB), .step (step),
        .stepLast (stepLast), .stepFirst (stepFirst), .limitB (sumC), .limitC (sumA),
        .creditSum (sumB), .status (statusB), .pwm (pwmB)
    );

    pwmGenerator phaseC (
        .clk (clk), .rstN (rstN), .cfg (cfg), .credit (cfg.creditC), .step (step),
        .stepLast (stepLast), .stepFirst (stepFirst), .limitB (sumA), .limitC (sumB),
        .creditSum (sumC), .status (statusC), .pwm (pwmC)
    );

endmodule

// File: testbench/motorPwmRef.svh
`ifndef MOTOR_PWM_REF_SVH
`define MOTOR_PWM_REF_SVH

// step in force at a given cycle, counted from the first enabled cycle
function automatic int stepAt(input longint cycle, input longint enCycle, input int stepLen);
    return int'(((cycle - enCycle) / stepLen) % `MOTOR_STEP_COUNT);
endfunction

// one period start: pulse width out, carried remainder updated
function automatic logic [`MOTOR_CREDIT_W-1:0] periodPulse(
    input  logic [`MOTOR_CREDIT_W-1:0]  credit,
    input  logic [`MOTOR_PERIOD_W-1:0]  minWidth,
    input  int                          step,
    input  logic [`MOTOR_CREDIT_W-1:0]  limitB,
    input  logic [`MOTOR_CREDIT_W-1:0]  limitC,
    inout  logic [`MOTOR_CREDIT_W-1:0]  rem
);
    logic [`MOTOR_CREDIT_W-1:0] total;
    logic                       held;
    total = rem + credit;
    held  = (total < minWidth);
    if ((step == `MOTOR_STEP_B) && (limitB < total)) begin
        held = 1'b1;
    end
    if ((step == `MOTOR_STEP_C) && (limitC < total)) begin
        held = 1'b1;
    end
    rem = held ? total : '0;
    return held ? '0 : total;
endfunction

// replays period starts after lastStart until one emits, -1 if none does
function automatic longint nextPulse(
    input  logic [`MOTOR_CREDIT_W-1:0]  credit,
    input  logic [`MOTOR_PERIOD_W-1:0]  minWidth,
    input  logic [`MOTOR_CREDIT_W-1:0]  limitB,
    input  logic [`MOTOR_CREDIT_W-1:0]  limitC,
    input  longint                      enCycle,
    input  int                          stepLen,
    input  int                          periodLen,
    input  longint                      lastStart,
    inout  logic [`MOTOR_CREDIT_W-1:0]  rem,
    output logic [`MOTOR_CREDIT_W-1:0]  width
);
    longint start;
    start = lastStart;
    width = '0;
    for (int n = 0; n < 64; n++) begin
        start = start + periodLen;
        width = periodPulse(credit, minWidth, stepAt(start, enCycle, stepLen), limitB, limitC, rem);
        if (width != '0) begin
            return start;
        end
    end
    return -1;
endfunction

// aligned step with every period emitting its credit
function automatic phaseStatus stepStatus(input logic [`MOTOR_CREDIT_W-1:0] credit,
                                          input int stepLen, input int periodLen);
    phaseStatus st;
    st.wantSum   = `MOTOR_CREDIT_W'(credit * (stepLen / periodLen));
    st.realCount = st.wantSum;
    return st;
endfunction

`endif

// File: testbench/tbMotorPwm.sv
`include "motorSettings.svh"

module tbMotorPwm;
    timeunit 1ns;
    timeprecision 1ps;
    import motorPkg::*;
    `include "motorPwmRef.svh"

    typedef struct packed {
        logic [1:0] phase;
        longint     rise;
        int         width;
    } pulseRec;

    logic   clk;
    logic   rstN;
    apbReq  apb;
    apbRsp  apbResp;
    logic   pwmA;
    logic   pwmB;
    logic   pwmC;

    int                         seed = 11;
    string                      testName = "reset";
    longint                     cycleNo = 0;
    longint                     lastAccessCycle;
    longint                     enCycle;
    int                         stepLen;
    int                         periodLen;
    logic [`MOTOR_PERIOD_W-1:0] minWidth;
    logic [`MOTOR_CREDIT_W-1:0] credits [3];
    logic                       armed = 1'b0;
    logic                       synced [3];
    longint                     prevRise [3];
    logic [`MOTOR_CREDIT_W-1:0] rem [3];
    int                         checkedCnt [3];
    int                         riseCnt [3];
    longint                     riseAt [3];
    logic [2:0]                 pwmPrev = '0;
    pulseRec                    pulseQ [$];

    motorPwmTop u_motorPwmTop (
        .clk     (clk),
        .rstN    (rstN),
        .apb     (apb),
        .apbResp (apbResp),
        .pwmA    (pwmA),
        .pwmB    (pwmB),
        .pwmC    (pwmC)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycleNo <= cycleNo + 1;

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic comparePulse(input string name, input logic [`MOTOR_CREDIT_W-1:0] expected,
                                input logic [`MOTOR_CREDIT_W-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", testName, name, expected, actual);
            stopRun("pulse check failed");
        end
    endtask

    task automatic compareStatus(input string name, input phaseStatus expected,
                                 input phaseStatus actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected want %0d real %0d, actual want %0d real %0d",
                     testName, name, expected.wantSum, expected.realCount,
                     actual.wantSum, actual.realCount);
            stopRun("status check failed");
        end
    endtask

    task automatic compareRsp(input string name, input apbRsp expected, input apbRsp actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %h/%b/%b, actual %h/%b/%b", testName, name,
                     expected.prdata, expected.pready, expected.pslverr,
                     actual.prdata, actual.pready, actual.pslverr);
            stopRun("APB response check failed");
        end
    endtask

    task automatic waitUntil(input longint target, input string what);
        int waitCnt;
        waitCnt = 0;
        while (cycleNo < target) begin
            @(negedge clk);
            waitCnt++;
            if (waitCnt > 5000) begin
                stopRun($sformatf("timed out waiting for %s", what));
            end
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        rstN = 1'b0;
        apb  = '0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
    endtask

    // setup and access phase, response sampled inside the access cycle
    task automatic apbTransfer(input logic write, input logic [`MOTOR_ADDR_W-1:0] addr,
                               input logic [31:0] data, output apbRsp rsp);
        int waitCnt;
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = write;
        apb.paddr   = addr;
        apb.pwdata  = data;
        @(negedge clk);
        apb.penable = 1'b1;
        #1;
        waitCnt = 0;
        while (apbResp.pready !== 1'b1) begin
            @(negedge clk);
            #1;
            waitCnt++;
            if (waitCnt > 16) begin
                stopRun("APB transfer timed out waiting for pready");
            end
        end
        rsp = apbResp;
        @(posedge clk);
        @(negedge clk);
        apb = '0;
        // first cycle in which a written value is in effect
        lastAccessCycle = cycleNo;
    endtask

    task automatic regWrite(input logic [`MOTOR_ADDR_W-1:0] addr, input logic [31:0] data);
        apbRsp rsp;
        apbTransfer(1'b1, addr, data, rsp);
        if (rsp.pslverr !== 1'b0) begin
            stopRun($sformatf("pslverr set on a write to register %h", addr));
        end
    endtask

    task automatic readCheck(input logic [`MOTOR_ADDR_W-1:0] addr, input logic [31:0] expected,
                             input logic expErr);
        apbRsp rsp;
        apbRsp exp;
        apbTransfer(1'b0, addr, '0, rsp);
        exp.prdata  = expected;
        exp.pready  = 1'b1;
        exp.pslverr = expErr;
        compareRsp($sformatf("read %h", addr), exp, rsp);
    endtask

    task automatic checkStatus(input int p, input phaseStatus expected);
        apbRsp      rspWant;
        apbRsp      rspReal;
        phaseStatus st;
        apbTransfer(1'b0, 8'(`MOTOR_REG_WANT_A + 4 * p), '0, rspWant);
        apbTransfer(1'b0, 8'(`MOTOR_REG_REAL_A + 4 * p), '0, rspReal);
        st.wantSum   = rspWant.prdata[`MOTOR_CREDIT_W-1:0];
        st.realCount = rspReal.prdata[`MOTOR_CREDIT_W-1:0];
        compareStatus($sformatf("phase %0d status", p), expected, st);
    endtask

    // writes the config, enables the timer and arms the pulse checker
    task automatic configure(input int period, input int minW, input int len,
                             input int cA, input int cB, input int cC);
        periodLen  = period;
        minWidth   = `MOTOR_PERIOD_W'(minW);
        stepLen    = len;
        credits[0] = `MOTOR_CREDIT_W'(cA);
        credits[1] = `MOTOR_CREDIT_W'(cB);
        credits[2] = `MOTOR_CREDIT_W'(cC);
        regWrite(`MOTOR_REG_PERIOD, period);
        regWrite(`MOTOR_REG_MINW, minW);
        regWrite(`MOTOR_REG_STEPLEN, len);
        regWrite(`MOTOR_REG_CREDIT_A, cA);
        regWrite(`MOTOR_REG_CREDIT_B, cB);
        regWrite(`MOTOR_REG_CREDIT_C, cC);
        regWrite(`MOTOR_REG_CTRL, 1);
        enCycle = lastAccessCycle;
        for (int p = 0; p < 3; p++) begin
            synced[p]     = 1'b0;
            checkedCnt[p] = 0;
            riseCnt[p]    = 0;
        end
        armed = 1'b1;
    endtask

    task automatic requireChecked(input int p, input int minCount);
        if (checkedCnt[p] < minCount) begin
            stopRun($sformatf("%s: too few pulses checked on phase %0d", testName, p));
        end
    endtask

    // the first pulse after the step realignment only syncs the replay
    task automatic checkPulse(input pulseRec rec);
        int                         p;
        longint                     start;
        logic [`MOTOR_CREDIT_W-1:0] width;
        p = int'(rec.phase);
        if (!armed) begin
            synced[p] = 1'b0;
            return;
        end
        if (rec.rise - 1 < enCycle + stepLen) begin
            return;
        end
        if (!synced[p]) begin
            synced[p]   = 1'b1;
            prevRise[p] = rec.rise;
            rem[p]      = '0;
            return;
        end
        start = nextPulse(credits[p], minWidth, credits[(p + 1) % 3], credits[(p + 2) % 3],
                          enCycle, stepLen, periodLen, prevRise[p] - 1, rem[p], width);
        if (start < 0) begin
            stopRun($sformatf("%s: phase %0d pulsed where none was expected", testName, p));
        end
        comparePulse($sformatf("phase %0d rise offset", p),
                     16'(start + 1 - prevRise[p]), 16'(rec.rise - prevRise[p]));
        comparePulse($sformatf("phase %0d width at cycle %0d", p, rec.rise), width, 16'(rec.width));
        prevRise[p] = rec.rise;
        checkedCnt[p]++;
    endtask

    always @(negedge clk) begin : pulseMonitor
        logic [2:0] now;
        pulseRec    rec;
        now = {pwmC, pwmB, pwmA};
        for (int p = 0; p < 3; p++) begin
            if (now[p] && !pwmPrev[p]) begin
                riseAt[p] = cycleNo;
                riseCnt[p]++;
            end
            if (!now[p] && pwmPrev[p]) begin
                rec.phase = 2'(p);
                rec.rise  = riseAt[p];
                rec.width = int'(cycleNo - riseAt[p]);
                pulseQ.push_back(rec);
            end
        end
        pwmPrev = now;
    end

    initial begin : pulseChecker
        pulseRec rec;
        forever begin
            @(negedge clk);
            while (pulseQ.size() > 0) begin
                rec = pulseQ.pop_front();
                checkPulse(rec);
            end
        end
    end

    initial begin : testSequence
        logic [31:0]                value;
        logic [31:0]                regExp [7];
        int                         fieldW [7];
        apbRsp                      rsp;
        apbRsp                      errRsp;
        int                         c;
        int                         b;
        logic [`MOTOR_ADDR_W-1:0]   badAddr [5];
        rstN   = 1'b0;
        apb    = '0;
        fieldW = '{1, 12, 12, 25, 16, 16, 16};
        badAddr = '{`MOTOR_REG_STEP, `MOTOR_REG_WANT_A, `MOTOR_REG_REAL_C, 8'h40, 8'hFC};
        errRsp.prdata  = '0;
        errRsp.pready  = 1'b1;
        errRsp.pslverr = 1'b1;

        testName = "register access";
        applyReset();
        if ({pwmC, pwmB, pwmA} !== 3'b000) begin
            stopRun("pwm outputs are not low after reset");
        end
        for (int i = 0; i < 14; i++) begin
            readCheck(8'(4 * i), '0, 1'b0);
        end
        for (int i = 0; i < 7; i++) begin
            value = $random(seed);
            // enable stays off so the status registers stay 0
            if (i == 0) begin
                value[0] = 1'b0;
            end
            regExp[i] = value & ((64'd1 << fieldW[i]) - 1);
            regWrite(8'(4 * i), value);
            readCheck(8'(4 * i), regExp[i], 1'b0);
        end
        foreach (badAddr[i]) begin
            apbTransfer(1'b1, badAddr[i], $random(seed), rsp);
            compareRsp($sformatf("bad write %h", badAddr[i]), errRsp, rsp);
        end
        readCheck(8'h40, '0, 1'b1);
        for (int i = 0; i < 14; i++) begin
            readCheck(8'(4 * i), (i < 7) ? regExp[i] : '0, 1'b0);
        end

        testName = "plain pulses";
        applyReset();
        c = 4 + ($unsigned($random(seed)) % 15);
        configure(20, 4, 60, c, c, c);
        for (int s = 0; s < 14; s++) begin
            waitUntil(enCycle + s * stepLen + 10, "step read point");
            readCheck(`MOTOR_REG_STEP, s % `MOTOR_STEP_COUNT, 1'b0);
            if (s >= 3) begin
                for (int p = 0; p < 3; p++) begin
                    checkStatus(p, stepStatus(credits[p], stepLen, periodLen));
                end
            end
        end
        armed = 1'b0;
        for (int p = 0; p < 3; p++) begin
            requireChecked(p, 20);
        end

        // steps 0 to 5 only, remainders of the phases may differ
        testName = "credit carry";
        applyReset();
        c = 2 + ($unsigned($random(seed)) % 8);
        configure(20, 10, 100, c, c, c);
        waitUntil(enCycle + 6 * stepLen - 2, "end of step 5");
        armed = 1'b0;
        for (int p = 0; p < 3; p++) begin
            requireChecked(p, 3);
        end

        testName = "zero credit";
        applyReset();
        c = 5 + ($unsigned($random(seed)) % 10);
        configure(20, 4, 60, c, c, 0);
        waitUntil(enCycle + 3 * stepLen + 10, "step 3");
        checkStatus(2, '0);
        checkStatus(0, stepStatus(credits[0], stepLen, periodLen));
        comparePulse("phase 2 rising edges", '0, 16'(riseCnt[2]));
        armed = 1'b0;

        // credits rise from B to C to A, so C is also held back in step 11
        testName = "cross-phase limit";
        applyReset();
        b = 4 + ($unsigned($random(seed)) % 2);
        c = b + 2 + ($unsigned($random(seed)) % (8 - b));
        configure(20, 4, 20, c, b, b + 1);
        waitUntil(enCycle + 15 * stepLen, "step 15");
        armed = 1'b0;
        requireChecked(0, 10);
        requireChecked(1, 10);
        requireChecked(2, 10);

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: project.f
+incdir+hdl
+incdir+testbench
hdl/motorPkg.sv
hdl/motorRegs.sv
hdl/commutationTimer.sv
hdl/pwmGenerator.sv
hdl/motorPwmTop.sv
testbench/tbMotorPwm.sv

// File: Bender.yml
package:
  name: motorPwm

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/motorPkg.sv
      - hdl/motorRegs.sv
      - hdl/commutationTimer.sv
      - hdl/pwmGenerator.sv
      - hdl/motorPwmTop.sv
  - target: test
    include_dirs:
      - hdl
      - testbench
    files:
      - testbench/tbMotorPwm.sv
